//--- design/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // data path width
    localparam int xlen = 64;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [7:0]      byte_mask_t;

    // data memory depth in doublewords
    localparam int dmem_words = 16;

    typedef logic [$clog2(dmem_words)-1:0] dmem_idx_t;

    // register reported as exit code on ebreak
    localparam int a0_idx = 10;

    // decoded operations
    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        ADDI,
        ADDW,
        MULW,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        LD,
        LW,
        LBU,
        SB,
        SH,
        SW,
        SD,
        EBREAK
    } exu_op_e;

    // alu functions
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_addw,
        alu_mulw
    } alu_mode_e;

endpackage

`default_nettype wire

//--- design/exu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module exu_regfile (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire exu_pkg::reg_idx_t ra_idx,
    input  wire exu_pkg::reg_idx_t rb_idx,
    input  wire logic             we,
    input  wire exu_pkg::reg_idx_t wd_idx,
    input  wire exu_pkg::xlen_t   wdata,
    output exu_pkg::xlen_t        ra_data,
    output exu_pkg::xlen_t        rb_data,
    output exu_pkg::xlen_t        a0_data
);

    exu_pkg::xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wd_idx != '0)) begin
            regs[wd_idx] <= wdata;
        end
    end

    // x0 reads as zero
    assign ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
    assign rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];

    assign a0_data = regs[exu_pkg::a0_idx];

endmodule

`default_nettype wire

//--- design/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    input  wire exu_pkg::alu_mode_e mode,
    input  wire exu_pkg::xlen_t     a,
    input  wire exu_pkg::xlen_t     b,
    output exu_pkg::xlen_t          result
);

    logic [5:0]  shamt;
    logic [31:0] sum_w;
    logic [31:0] prod_w;
    logic        lt_s;
    logic        lt_u;

    assign shamt = b[5:0];

    // word forms work on the low halves
    assign sum_w  = a[31:0] + b[31:0];
    assign prod_w = a[31:0] * b[31:0];

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        result = '0;
        case (mode)
            exu_pkg::alu_add: begin
                result = a + b;
            end
            exu_pkg::alu_sub: begin
                result = a - b;
            end
            exu_pkg::alu_and: begin
                result = a & b;
            end
            exu_pkg::alu_or: begin
                result = a | b;
            end
            exu_pkg::alu_xor: begin
                result = a ^ b;
            end
            exu_pkg::alu_slt: begin
                result = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
            end
            exu_pkg::alu_sltu: begin
                result = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
            end
            exu_pkg::alu_sll: begin
                result = a << shamt;
            end
            exu_pkg::alu_srl: begin
                result = a >> shamt;
            end
            exu_pkg::alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            // sign-extend 32-bit results
            exu_pkg::alu_addw: begin
                result = {{32{sum_w[31]}}, sum_w};
            end
            exu_pkg::alu_mulw: begin
                result = {{32{prod_w[31]}}, prod_w};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/exu_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_lsu (
    input  wire exu_pkg::exu_op_e op,
    input  wire exu_pkg::xlen_t   addr,
    input  wire exu_pkg::xlen_t   store_data,
    input  wire exu_pkg::xlen_t   rdata,
    output logic                  mem_we,
    output exu_pkg::dmem_idx_t    mem_idx,
    output exu_pkg::xlen_t        mem_wdata,
    output exu_pkg::byte_mask_t   mem_wmask,
    output exu_pkg::xlen_t        load_data
);

    logic [2:0]     lane;
    logic [5:0]     bit_ofs;
    exu_pkg::xlen_t lane_data;

    assign lane    = addr[2:0];
    assign bit_ofs = {lane, 3'b000};

    // doubleword index, wraps every 128 bytes
    assign mem_idx = addr[6:3];

    // store lanes and byte enables
    always_comb begin
        mem_we    = 1'b0;
        mem_wmask = '0;
        mem_wdata = '0;
        case (op)
            exu_pkg::SB: begin
                mem_we    = 1'b1;
                mem_wmask = 8'h01 << lane;
                mem_wdata = {56'b0, store_data[7:0]} << bit_ofs;
            end
            exu_pkg::SH: begin
                mem_we    = 1'b1;
                mem_wmask = 8'h03 << lane;
                mem_wdata = {48'b0, store_data[15:0]} << bit_ofs;
            end
            exu_pkg::SW: begin
                mem_we    = 1'b1;
                mem_wmask = 8'h0f << lane;
                mem_wdata = {32'b0, store_data[31:0]} << bit_ofs;
            end
            exu_pkg::SD: begin
                mem_we    = 1'b1;
                mem_wmask = 8'hff;
                mem_wdata = store_data;
            end
            default: begin
                mem_we    = 1'b0;
            end
        endcase
    end

    // addressed lane moved down to bit 0
    assign lane_data = rdata >> bit_ofs;

    always_comb begin
        load_data = '0;
        case (op)
            exu_pkg::LD: begin
                load_data = rdata;
            end
            exu_pkg::LW: begin
                load_data = {{32{lane_data[31]}}, lane_data[31:0]};
            end
            exu_pkg::LBU: begin
                load_data = {56'b0, lane_data[7:0]};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/exu_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module exu_dmem (
    input  wire logic                clk,
    input  wire logic                we,
    input  wire exu_pkg::dmem_idx_t  idx,
    input  wire exu_pkg::xlen_t      wdata,
    input  wire exu_pkg::byte_mask_t wmask,
    output exu_pkg::xlen_t           rdata
);

    exu_pkg::xlen_t mem [exu_pkg::dmem_words];

    // only enabled bytes change
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 8; i++) begin
                if (wmask[i]) begin
                    mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- design/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              valid,
    input  wire exu_pkg::exu_op_e  op,
    input  wire exu_pkg::reg_idx_t rd,
    input  wire exu_pkg::reg_idx_t rs1,
    input  wire exu_pkg::reg_idx_t rs2,
    input  wire exu_pkg::xlen_t    imm,
    input  wire exu_pkg::xlen_t    pc,
    output exu_pkg::xlen_t         dnpc,
    output logic                   retire_en,
    output exu_pkg::reg_idx_t      retire_rd,
    output exu_pkg::xlen_t         retire_data,
    output logic                   halted,
    output exu_pkg::xlen_t         exit_code
);

    logic                accept;
    logic                writes_rd;
    logic                rf_we;
    logic                taken;
    logic                lsu_we;
    exu_pkg::xlen_t      src1;
    exu_pkg::xlen_t      src2;
    exu_pkg::xlen_t      a0_data;
    exu_pkg::xlen_t      snpc;
    exu_pkg::xlen_t      alu_a;
    exu_pkg::xlen_t      alu_b;
    exu_pkg::xlen_t      alu_result;
    exu_pkg::xlen_t      wb_data;
    exu_pkg::xlen_t      load_data;
    exu_pkg::xlen_t      mem_rdata;
    exu_pkg::xlen_t      mem_wdata;
    exu_pkg::byte_mask_t mem_wmask;
    exu_pkg::dmem_idx_t  mem_idx;
    exu_pkg::alu_mode_e  alu_mode;

    assign accept = valid && !halted;
    assign snpc   = pc + 64'd4;

    // alu function and operand sources
    always_comb begin
        alu_mode = exu_pkg::alu_add;
        alu_a    = src1;
        alu_b    = src2;
        case (op)
            exu_pkg::SUB:  alu_mode = exu_pkg::alu_sub;
            exu_pkg::AND:  alu_mode = exu_pkg::alu_and;
            exu_pkg::OR:   alu_mode = exu_pkg::alu_or;
            exu_pkg::XOR:  alu_mode = exu_pkg::alu_xor;
            exu_pkg::SLT:  alu_mode = exu_pkg::alu_slt;
            exu_pkg::SLTU: alu_mode = exu_pkg::alu_sltu;
            exu_pkg::SLL:  alu_mode = exu_pkg::alu_sll;
            exu_pkg::SRL:  alu_mode = exu_pkg::alu_srl;
            exu_pkg::SRA:  alu_mode = exu_pkg::alu_sra;
            exu_pkg::ADDW: alu_mode = exu_pkg::alu_addw;
            exu_pkg::MULW: alu_mode = exu_pkg::alu_mulw;
            exu_pkg::AUIPC, exu_pkg::JAL: begin
                alu_a = pc;
                alu_b = imm;
            end
            exu_pkg::ADDI, exu_pkg::JALR, exu_pkg::LD, exu_pkg::LW, exu_pkg::LBU,
            exu_pkg::SB, exu_pkg::SH, exu_pkg::SW, exu_pkg::SD: begin
                alu_b = imm;
            end
            default: alu_mode = exu_pkg::alu_add;
        endcase
    end

    // write-back source
    always_comb begin
        writes_rd = 1'b1;
        wb_data   = alu_result;
        case (op)
            exu_pkg::LUI:  wb_data = imm;
            exu_pkg::JAL, exu_pkg::JALR: wb_data = snpc;
            exu_pkg::LD, exu_pkg::LW, exu_pkg::LBU: wb_data = load_data;
            exu_pkg::BEQ, exu_pkg::BNE, exu_pkg::BLT, exu_pkg::BGE,
            exu_pkg::SB, exu_pkg::SH, exu_pkg::SW, exu_pkg::SD,
            exu_pkg::EBREAK: writes_rd = 1'b0;
            default: wb_data = alu_result;
        endcase
    end

    assign rf_we       = accept && writes_rd;
    assign retire_en   = rf_we && (rd != '0);
    assign retire_rd   = rd;
    assign retire_data = wb_data;

    // branch compare on register values
    always_comb begin
        case (op)
            exu_pkg::BEQ: taken = (src1 == src2);
            exu_pkg::BNE: taken = (src1 != src2);
            exu_pkg::BLT: taken = ($signed(src1) < $signed(src2));
            exu_pkg::BGE: taken = ($signed(src1) >= $signed(src2));
            default:      taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            exu_pkg::JAL:  dnpc = alu_result;
            exu_pkg::JALR: dnpc = {alu_result[63:1], 1'b0};
            default:       dnpc = taken ? (pc + imm) : snpc;
        endcase
    end

    // halt and exit code hold until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted    <= 1'b0;
            exit_code <= '0;
        end else if (accept && (op == exu_pkg::EBREAK)) begin
            halted    <= 1'b1;
            exit_code <= a0_data;
        end
    end

    exu_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra_idx  (rs1),
        .rb_idx  (rs2),
        .we      (rf_we),
        .wd_idx  (rd),
        .wdata   (wb_data),
        .ra_data (src1),
        .rb_data (src2),
        .a0_data (a0_data)
    );

    exu_alu u_alu (
        .mode   (alu_mode),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    exu_lsu u_lsu (
        .op         (op),
        .addr       (alu_result),
        .store_data (src2),
        .rdata      (mem_rdata),
        .mem_we     (lsu_we),
        .mem_idx    (mem_idx),
        .mem_wdata  (mem_wdata),
        .mem_wmask  (mem_wmask),
        .load_data  (load_data)
    );

    exu_dmem u_dmem (
        .clk   (clk),
        .we    (lsu_we && accept),
        .idx   (mem_idx),
        .wdata (mem_wdata),
        .wmask (mem_wmask),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- test/exu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exu_sva (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic              valid,
    input wire logic              retire_en,
    input wire exu_pkg::reg_idx_t retire_rd,
    input wire logic              halted
);

    // x0 is never reported as written
    retire_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        retire_en |-> (retire_rd != '0))
        else $error("retire_en high with retire_rd zero");

    no_retire_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!valid || halted) |-> !retire_en)
        else $error("retire_en high while idle or halted");

    // only reset clears the halt
    halt_holds: assert property (@(posedge clk)
        (rst_n && halted) |=> halted)
        else $error("halted fell without reset");

endmodule

`default_nettype wire

//--- test/exu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exu_checker (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              valid,
    input  wire exu_pkg::exu_op_e  op,
    input  wire exu_pkg::reg_idx_t rd,
    input  wire exu_pkg::reg_idx_t rs1,
    input  wire exu_pkg::reg_idx_t rs2,
    input  wire exu_pkg::xlen_t    imm,
    input  wire exu_pkg::xlen_t    pc,
    input  wire exu_pkg::xlen_t    dnpc,
    input  wire logic              retire_en,
    input  wire exu_pkg::reg_idx_t retire_rd,
    input  wire exu_pkg::xlen_t    retire_data,
    input  wire logic              halted,
    input  wire exu_pkg::xlen_t    exit_code,
    output exu_pkg::xlen_t         model_pc
);

    exu_pkg::xlen_t regs [32];
    logic [7:0]     mem [128];
    logic           m_halted;
    exu_pkg::xlen_t m_exit;
    int             errors [6] = '{default: 0};
    int             checks [6] = '{default: 0};

    task automatic compare(input int t, input string name, input logic [63:0] got,
                           input logic [63:0] exp);
        checks[t]++;
        if (got !== exp) begin
            errors[t]++;
            $display("MISMATCH %s: got %h expected %h (pc %h, op %0d)", name, got, exp, pc, op);
        end
    endtask

    // little-endian read, zero-extended, wraps at 128 bytes
    function automatic exu_pkg::xlen_t read_bytes(input logic [6:0] addr, input int n);
        exu_pkg::xlen_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k*8 +: 8] = mem[7'(addr + k)];
        end
        return v;
    endfunction

    task automatic write_bytes(input logic [6:0] addr, input int n, input exu_pkg::xlen_t v);
        for (int k = 0; k < n; k++) begin
            mem[7'(addr + k)] = v[k*8 +: 8];
        end
    endtask

    always @(posedge clk) begin
        exu_pkg::xlen_t a;
        exu_pkg::xlen_t b;
        exu_pkg::xlen_t sum;
        exu_pkg::xlen_t wb;
        exu_pkg::xlen_t npc;
        exu_pkg::xlen_t p;
        logic           wr;
        logic           exp_ret;
        int             t;
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            m_halted = 1'b0;
            m_exit   = '0;
            model_pc <= '0;
        end else begin
            compare(5, "halted", halted, m_halted);
            compare(5, "exit_code", exit_code, m_exit);
            if (!valid || m_halted) begin
                compare(valid ? 5 : 4, "retire_en", retire_en, 1'b0);
                model_pc <= pc;
            end else begin
                a   = regs[rs1];
                b   = regs[rs2];
                sum = a + imm;
                wb  = '0;
                wr  = 1'b1;
                npc = pc + 64'd4;
                t   = 0;
                case (op)
                    exu_pkg::ADD:  wb = a + b;
                    exu_pkg::SUB:  wb = a - b;
                    exu_pkg::AND:  wb = a & b;
                    exu_pkg::OR:   wb = a | b;
                    exu_pkg::XOR:  wb = a ^ b;
                    exu_pkg::SLT:  wb = {63'b0, $signed(a) < $signed(b)};
                    exu_pkg::SLTU: wb = {63'b0, a < b};
                    exu_pkg::SLL:  wb = a << b[5:0];
                    exu_pkg::SRL:  wb = a >> b[5:0];
                    exu_pkg::SRA:  wb = $signed(a) >>> b[5:0];
                    exu_pkg::ADDI: wb = sum;
                    exu_pkg::ADDW: begin
                        // low word of the full sum, sign-extended
                        wb = a + b;
                        wb = {{32{wb[31]}}, wb[31:0]};
                    end
                    exu_pkg::MULW: begin
                        p  = a * b;
                        wb = {{32{p[31]}}, p[31:0]};
                    end
                    exu_pkg::LUI, exu_pkg::AUIPC, exu_pkg::JAL, exu_pkg::JALR: begin
                        t   = 1;
                        wb  = (op == exu_pkg::LUI) ? imm :
                              (op == exu_pkg::AUIPC) ? pc + imm : pc + 64'd4;
                        npc = (op == exu_pkg::JAL) ? pc + imm :
                              (op == exu_pkg::JALR) ? {sum[63:1], 1'b0} : pc + 64'd4;
                    end
                    exu_pkg::BEQ, exu_pkg::BNE, exu_pkg::BLT, exu_pkg::BGE: begin
                        t  = 2;
                        wr = 1'b0;
                        if ((op == exu_pkg::BEQ && a == b) || (op == exu_pkg::BNE && a != b) ||
                            (op == exu_pkg::BLT && $signed(a) < $signed(b)) ||
                            (op == exu_pkg::BGE && $signed(a) >= $signed(b))) begin
                            npc = pc + imm;
                        end
                    end
                    exu_pkg::LD:  begin
                        t  = 3;
                        wb = read_bytes(sum[6:0], 8);
                    end
                    exu_pkg::LW:  begin
                        t  = 3;
                        wb = read_bytes(sum[6:0], 4);
                        wb = {{32{wb[31]}}, wb[31:0]};
                    end
                    exu_pkg::LBU: begin
                        t  = 3;
                        wb = read_bytes(sum[6:0], 1);
                    end
                    exu_pkg::SB, exu_pkg::SH, exu_pkg::SW, exu_pkg::SD: begin
                        t  = 3;
                        wr = 1'b0;
                        write_bytes(sum[6:0], (op == exu_pkg::SB) ? 1 : (op == exu_pkg::SH) ? 2 :
                                    (op == exu_pkg::SW) ? 4 : 8, b);
                    end
                    default: begin
                        // ebreak
                        t        = 5;
                        wr       = 1'b0;
                        m_halted = 1'b1;
                        m_exit   = regs[exu_pkg::a0_idx];
                    end
                endcase
                exp_ret = wr && (rd != '0);
                compare(t, "dnpc", dnpc, npc);
                compare((wr && rd == '0) ? 4 : t, "retire_en", retire_en, exp_ret);
                if (exp_ret) begin
                    compare(t, "retire_rd", retire_rd, rd);
                    compare(t, "retire_data", retire_data, wb);
                    regs[rd] = wb;
                end
                model_pc <= npc;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;

    logic              clk;
    logic              rst_n;
    logic              valid;
    exu_pkg::exu_op_e  op;
    exu_pkg::reg_idx_t rd;
    exu_pkg::reg_idx_t rs1;
    exu_pkg::reg_idx_t rs2;
    exu_pkg::xlen_t    imm;
    exu_pkg::xlen_t    pc;
    exu_pkg::xlen_t    dnpc;
    logic              retire_en;
    exu_pkg::reg_idx_t retire_rd;
    exu_pkg::xlen_t    retire_data;
    logic              halted;
    exu_pkg::xlen_t    exit_code;
    exu_pkg::xlen_t    model_pc;
    integer            seed;
    int                timeouts;
    int                total_err;
    int                total_chk;
    int                errs;
    string             names [6] = '{"alu ops", "upper and jumps", "branches",
                                     "loads and stores", "x0 and idle", "ebreak"};

    exu_top UUT (.*);

    exu_checker u_checker (.*);

    bind exu_top exu_sva u_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .retire_en (retire_en),
        .retire_rd (retire_rd),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one instruction per falling edge, pc follows the model
    task automatic issue(input logic v, input exu_pkg::exu_op_e o, input exu_pkg::reg_idx_t d,
                         input exu_pkg::reg_idx_t s1, input exu_pkg::reg_idx_t s2,
                         input exu_pkg::xlen_t i);
        @(negedge clk);
        valid = v;
        op    = o;
        rd    = d;
        rs1   = s1;
        rs2   = s2;
        imm   = i;
        pc    = model_pc;
    endtask

    task automatic send_random();
        int               k;
        int               sz;
        logic [31:0]      r;
        logic             v;
        exu_pkg::exu_op_e o;
        exu_pkg::reg_idx_t s1;
        exu_pkg::xlen_t   i;
        k  = $unsigned($random(seed)) % 28;
        o  = exu_pkg::exu_op_e'(k);
        v  = ($unsigned($random(seed)) % 8) != 0;
        s1 = $random(seed);
        r  = $random(seed);
        i  = {{52{r[11]}}, r[11:0]};
        case (o)
            exu_pkg::ADDI, exu_pkg::LUI, exu_pkg::AUIPC: i = {$random(seed), r};
            exu_pkg::LD, exu_pkg::LW, exu_pkg::LBU,
            exu_pkg::SB, exu_pkg::SH, exu_pkg::SW, exu_pkg::SD: begin
                sz = (o == exu_pkg::LD || o == exu_pkg::SD) ? 8 :
                     (o == exu_pkg::LW || o == exu_pkg::SW) ? 4 :
                     (o == exu_pkg::SH) ? 2 : 1;
                // zero base plus an aligned offset
                s1 = '0;
                i  = (r % 128) & ~(sz - 1);
            end
            default: ;
        endcase
        issue(v, o, $random(seed), s1, $random(seed), i);
    endtask

    task automatic wait_halted(input int limit);
        int n;
        n = 0;
        while (!halted && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("timeout: halted did not rise after ebreak");
            timeouts++;
        end
    endtask

    initial begin
        seed      = 77019;
        timeouts  = 0;
        total_err = 0;
        total_chk = 0;
        rst_n     = 1'b0;
        valid     = 1'b0;
        op        = exu_pkg::ADD;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        pc        = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        // fill every doubleword through x5
        for (int w = 0; w < exu_pkg::dmem_words; w++) begin
            issue(1'b1, exu_pkg::LUI, 5'd5, 5'd0, 5'd0, {$random(seed), $random(seed)});
            issue(1'b1, exu_pkg::SD, 5'd0, 5'd0, 5'd5, exu_pkg::xlen_t'(w * 8));
        end
        repeat (600) send_random();
        issue(1'b1, exu_pkg::EBREAK, 5'd0, 5'd0, 5'd0, '0);
        wait_halted(8);
        repeat (4) issue(1'b1, exu_pkg::ADDI, 5'd1, 5'd0, 5'd0, 64'd1);
        @(negedge clk);
        for (int t = 0; t < 6; t++) begin
            errs = u_checker.errors[t] + ((t == 5) ? timeouts : 0);
            if (u_checker.checks[t] == 0) begin
                errs++;
            end
            total_err += errs;
            total_chk += u_checker.checks[t];
            $display("test %0d %s: %0d checks, %0d errors, %s", t + 1, names[t],
                     u_checker.checks[t], errs, (errs == 0) ? "ok" : "failed");
        end
        $display("checks %0d, errors %0d", total_chk, total_err);
        if (total_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
design/exu_pkg.sv
design/exu_regfile.sv
design/exu_alu.sv
design/exu_lsu.sv
design/exu_dmem.sv
design/exu_top.sv
test/exu_sva.sv
test/exu_checker.sv
test/tb_exu_top.sv

//--- Bender.yml
package:
  name: exu

sources:
  - files:
      - design/exu_pkg.sv
      - design/exu_regfile.sv
      - design/exu_alu.sv
      - design/exu_lsu.sv
      - design/exu_dmem.sv
      - design/exu_top.sv
  - target: test
    files:
      - test/exu_sva.sv
      - test/exu_checker.sv
      - test/tb_exu_top.sv
